//--- Makefile
# Verilator flow for the DAC sample path testbench

TOP := dac_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f list.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- bench/dac_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_cfg.svh"

module dac_tb
	import dac_data_pkg::*;
	import dac_reg_pkg::*;
();

	localparam int WORD_W         = `DAC_SAMPLES * `DAC_SAMPLE_W;
	localparam int OCTETS         = WORD_W / 8;
	localparam int TEST_CYCLES    = 1000;						// all sections, rounded up
	localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

	logic        w_glbclk1 = 1'b0;
	logic        rst_n;
	dac_bus_t    dac_data_in;
	link_stat_t  link_stat;
	reg_req_t    reg_req;
	reg_rsp_t    reg_rsp;
	dac_bus_t    tx_data;
	logic        dac_ready;
	logic        dac_lmfc;

	int          err_cnt;
	int          cycle_cnt;
	int          word_checks;
	int          low_ready;

	dac_bus_t    hist_in  [0:2];							// [0] newest capture
	logic        hist_sel [1:2];
	dac_word_t   hist_pat [1:2];
	int          hist_cnt;
	logic        model_sel;									// expected REG_CTRL bit 0
	dac_word_t   model_pat;

	always #2 w_glbclk1 = ~w_glbclk1;						// 4 ns period

	dac_top dut0 (
		.w_glbclk1   ( w_glbclk1   ),
		.rst_n       ( rst_n       ),
		.dac_data_in ( dac_data_in ),
		.link_stat   ( link_stat   ),
		.reg_req     ( reg_req     ),
		.reg_rsp     ( reg_rsp     ),
		.tx_data     ( tx_data     ),
		.dac_ready   ( dac_ready   ),
		.dac_lmfc    ( dac_lmfc    )
	);

	// **************************************************
	// reference model and helpers
	// **************************************************

	// link word is the selected word with its 16 octets reversed
	function automatic dac_word_t expected_word(input dac_word_t din, input logic tsel,
		input dac_word_t pat);
		logic [WORD_W-1:0] src;
		logic [WORD_W-1:0] res;
		src = tsel ? pat : din;
		for (int k = 0; k < OCTETS; k++)
			res[8*k +: 8] = src[8*(OCTETS-1-k) +: 8];
		return res;
	endfunction

	function automatic dac_bus_t random_bus();
		logic [`DAC_NUM_CH*WORD_W-1:0] flat;
		for (int i = 0; i < `DAC_NUM_CH*WORD_W/32; i++)
			flat[32*i +: 32] = $urandom();
		return flat;
	endfunction

	task automatic check_value(input string name, input logic [WORD_W-1:0] expected,
		input logic [WORD_W-1:0] actual);
		if (actual !== expected) begin
			err_cnt++;
			$display("** Error %s: expected %h, actual %h (t=%0t)", name, expected, actual,
				$time);
		end
	endtask

	task automatic step();
		@(posedge w_glbclk1);
		#1;													// drive point after the edge
	endtask

	task automatic reg_write(input logic [`DAC_REG_AW-1:0] addr,
		input logic [`DAC_REG_DW-1:0] data);
		reg_req.wr    = 1'b1;
		reg_req.addr  = reg_addr_e'(addr);
		reg_req.wdata = data;
		step();
		reg_req.wr = 1'b0;
	endtask

	// answer is due exactly one cycle after the strobe edge
	task automatic reg_read(input logic [`DAC_REG_AW-1:0] addr,
		input logic [`DAC_REG_DW-1:0] expected);
		reg_req.rd   = 1'b1;
		reg_req.addr = reg_addr_e'(addr);
		step();
		reg_req.rd = 1'b0;
		if (reg_rsp.rvalid !== 1'b1) begin
			err_cnt++;
			$display("read of register %0d got no rvalid one cycle after the strobe", addr);
		end
		check_value($sformatf("reg_rsp.rdata[%0d]", addr), WORD_W'(expected),
			WORD_W'(reg_rsp.rdata));
		step();
		if (reg_rsp.rvalid !== 1'b0) begin
			err_cnt++;
			$display("rvalid stayed high longer than one cycle after reading register %0d", addr);
		end
	endtask

	task automatic random_cycles(input int n);
		repeat (n) begin
			dac_data_in = random_bus();
			step();
		end
	endtask

	// **************************************************
	// compare process
	// **************************************************

	initial begin
		hist_cnt  = 0;
		model_sel = 1'b0;
		model_pat = '0;
		forever begin
			@(posedge w_glbclk1);
			if (!rst_n) begin
				hist_cnt  = 0;									// pipeline flushed by reset
				model_sel = 1'b0;
				model_pat = '0;
			end else begin
				hist_in[2]  = hist_in[1];
				hist_sel[2] = hist_sel[1];
				hist_pat[2] = hist_pat[1];
				hist_in[1]  = hist_in[0];
				hist_in[0]  = dac_data_in;
				hist_sel[1] = model_sel;						// select seen one edge after capture
				hist_pat[1] = model_pat;
				if (reg_req.wr) begin
					if (reg_req.addr <= REG_PAT7)
						model_pat[reg_req.addr[2:0]] = reg_req.wdata;
					else if (reg_req.addr == REG_CTRL)
						model_sel = reg_req.wdata[0];
				end
				if (hist_cnt < 3)
					hist_cnt++;
			end
			@(negedge w_glbclk1);
			if (rst_n && hist_cnt == 3) begin
				for (int ch = 0; ch < `DAC_NUM_CH; ch++)
					check_value($sformatf("tx_data[%0d]", ch),
						expected_word(hist_in[2][ch], hist_sel[2], hist_pat[2]), tx_data[ch]);
				word_checks++;
			end
		end
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge w_glbclk1);
			cycle_cnt++;
		end
		$display("run stopped after %0d cycles without reaching the end of the tests", cycle_cnt);
		$display("SIMULATION FAILED");
		$finish;
	end

	// **************************************************
	// stimulus
	// **************************************************

	initial begin
		link_stat_t  stat;
		dac_word_t   pat_word;
		logic [31:0] rnd;
		void'($urandom(8980));
		err_cnt     = 0;
		word_checks = 0;
		low_ready   = 0;
		rst_n       = 1'b0;
		dac_data_in = '0;
		reg_req     = '0;
		reg_req.rd  = 1'b1;										// read strobe held through reset
		link_stat.tready = '1;									// status high, outputs must stay low
		link_stat.sof_mf = '1;

		repeat (4) begin
			step();
			dac_data_in = random_bus();
		end
		check_value("tx_data", '0, tx_data[0] | tx_data[1] | tx_data[2] | tx_data[3]);
		check_value("dac_ready", '0, WORD_W'(dac_ready));
		check_value("dac_lmfc", '0, WORD_W'(dac_lmfc));
		check_value("reg_rsp.rvalid", '0, WORD_W'(reg_rsp.rvalid));
		rst_n       = 1'b1;
		reg_req.rd  = 1'b0;
		link_stat   = '0;
		dac_data_in = '0;
		step();
		check_value("tx_data", '0, tx_data[0] | tx_data[1] | tx_data[2] | tx_data[3]);
		check_value("dac_ready", '0, WORD_W'(dac_ready));
		check_value("dac_lmfc", '0, WORD_W'(dac_lmfc));
		check_value("reg_rsp.rvalid", '0, WORD_W'(reg_rsp.rvalid));

		random_cycles(300);										// user data back to back

		// register map
		for (int i = 0; i < `DAC_SAMPLES; i++) begin
			rnd = $urandom();
			pat_word[i] = rnd[15:0];
			reg_write(4'(i), rnd[15:0]);
		end
		for (int i = 0; i < `DAC_SAMPLES; i++)
			reg_read(4'(i), pat_word[i]);
		reg_write(REG_CTRL, 16'h5A5A);							// bit 0 clear
		reg_read(REG_CTRL, 16'h0000);
		reg_read(REG_ID, `DAC_ID_VALUE);
		reg_write(REG_ID, 16'h1111);
		reg_read(REG_ID, `DAC_ID_VALUE);
		for (int a = 10; a < 16; a++) begin
			reg_write(4'(a), 16'hFFFF);
			reg_read(4'(a), 16'h0000);
		end

		// test pattern on every channel
		for (int i = 0; i < `DAC_SAMPLES; i++) begin
			rnd = $urandom();
			pat_word[i] = rnd[15:0];
			reg_write(4'(i), rnd[15:0]);
		end
		reg_write(REG_CTRL, 16'h0001);
		reg_read(REG_CTRL, 16'h0001);
		random_cycles(4);										// settle
		repeat (40) begin
			dac_data_in = random_bus();
			step();
			for (int ch = 0; ch < `DAC_NUM_CH; ch++)
				check_value($sformatf("tx_data[%0d]", ch), expected_word('0, 1'b1, pat_word),
					tx_data[ch]);
		end
		reg_write(REG_CTRL, 16'h0000);
		random_cycles(4);
		random_cycles(60);										// user data again

		// link status, data keeps moving
		for (int i = 0; i < 200; i++) begin
			rnd  = $urandom();
			stat = rnd[7:0];
			if (i % 8 == 0)
				stat.tready = '1;								// all cores ready now and then
			link_stat   = stat;
			dac_data_in = random_bus();
			step();
			check_value("dac_ready", WORD_W'(&stat.tready), WORD_W'(dac_ready));
			check_value("dac_lmfc", WORD_W'(|stat.sof_mf), WORD_W'(dac_lmfc));
			if (!(&stat.tready))
				low_ready++;
		end

		dac_data_in = '0;
		repeat (4) step();										// drain the pipeline
		if (word_checks < 600) begin
			err_cnt++;
			$display("only %0d output words were compared, fewer than the tests drove",
				word_checks);
		end

		$display("words compared %0d, cycles with dac_ready low %0d, errors %0d",
			word_checks, low_ready, err_cnt);
		if (err_cnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/dac_capture_stage.sv
`timescale 1ns/1ps
`default_nettype none

// input boundary of the sample path, ahead of any selection or mapping
module dac_capture_stage
	import dac_data_pkg::*;
(
	input  wire logic w_glbclk1,
	input  wire logic rst_n,
	input  dac_bus_t  data_in,
	output dac_bus_t  data_out
);

	dac_bus_t data_q;

	// **************************************************
	// stage 1 register
	// **************************************************

	always_ff @(posedge w_glbclk1 or negedge rst_n) begin
		if (!rst_n)
			data_q <= '0;								// quiet link after reset
		else
			data_q <= data_in;							// all channels every edge
	end

	assign data_out = data_q;

endmodule

`default_nettype wire

//--- hdl/dac_cfg.svh
`ifndef DAC_CFG_SVH
`define DAC_CFG_SVH

// **************************************************
// sample path geometry
// **************************************************

// one word per JESD204B link core
`define DAC_NUM_CH		4
`define DAC_SAMPLE_W	16						// bits per DAC sample
`define DAC_SAMPLES		8						// samples per channel word

// **************************************************
// register bank
// **************************************************

`define DAC_REG_AW		4						// address bits
`define DAC_REG_DW		16						// data bits, one sample wide

// fixed content of the read-only id register
`define DAC_ID_VALUE	16'hDA04

`endif

//--- hdl/dac_data_pkg.sv
`default_nettype none

`include "dac_cfg.svh"

package dac_data_pkg;

	// **************************************************
	// sample path types
	// **************************************************

	typedef logic [`DAC_SAMPLE_W-1:0] dac_sample_t;

	// sample 0 sits in the low bits
	typedef dac_sample_t [`DAC_SAMPLES-1:0] dac_word_t;		// one channel, 128 bits

	typedef dac_word_t [`DAC_NUM_CH-1:0] dac_bus_t;			// all channels, 512 bits

	// **************************************************
	// link core status
	// **************************************************

	// status of the external JESD204B cores
	typedef struct packed {
		logic [`DAC_NUM_CH-1:0] tready;					// one per link core
		logic [`DAC_NUM_CH-1:0] sof_mf;					// core 0, one per lane
	} link_stat_t;

endpackage

`default_nettype wire

//--- hdl/dac_lane_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_cfg.svh"

module dac_lane_stage
	import dac_data_pkg::*;
(
	input  wire logic  w_glbclk1,
	input  wire logic  rst_n,
	input  dac_bus_t   data_in,
	input  link_stat_t link_stat,
	output dac_bus_t   tx_data,
	output logic       dac_ready,
	output logic       dac_lmfc
);

	localparam int OCTETS = (`DAC_SAMPLES * `DAC_SAMPLE_W) / 8;	// 16 per word

	dac_bus_t map_data;
	dac_bus_t tx_q;
	logic     ready_q;
	logic     lmfc_q;

	// octet k of the link word comes from octet OCTETS-1-k of the sample word
	function automatic dac_word_t octet_swap(input dac_word_t word);
		logic [OCTETS*8-1:0] flat_in;
		logic [OCTETS*8-1:0] flat_out;
		flat_in = word;									// bit view of the samples
		for (int k = 0; k < OCTETS; k++)
			flat_out[8*k +: 8] = flat_in[8*(OCTETS-1-k) +: 8];
		return flat_out;
	endfunction

	// **************************************************
	// octet mapping for the link cores
	// **************************************************

	always_comb begin
		for (int ch = 0; ch < `DAC_NUM_CH; ch++)
			map_data[ch] = octet_swap(data_in[ch]);
	end

	// **************************************************
	// stage 3 register and link status
	// **************************************************

	always_ff @(posedge w_glbclk1 or negedge rst_n) begin
		if (!rst_n) begin
			tx_q    <= '0;
			ready_q <= 1'b0;
			lmfc_q  <= 1'b0;
		end else begin
			tx_q    <= map_data;						// no back-pressure on tready
			ready_q <= &link_stat.tready;				// every core ready
			lmfc_q  <= |link_stat.sof_mf;				// any lane at multiframe start
		end
	end

	assign tx_data   = tx_q;
	assign dac_ready = ready_q;
	assign dac_lmfc  = lmfc_q;

endmodule

`default_nettype wire

//--- hdl/dac_pattern_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_cfg.svh"

module dac_pattern_stage
	import dac_data_pkg::*;
(
	input  wire logic w_glbclk1,
	input  wire logic rst_n,
	input  dac_bus_t  data_in,
	input  wire logic test_sel,
	input  dac_word_t pattern,
	output dac_bus_t  data_out
);

	dac_bus_t sel_data;
	dac_bus_t data_q;

	// **************************************************
	// user data or test pattern
	// **************************************************

	// same pattern goes out on every channel in test mode
	always_comb begin
		for (int ch = 0; ch < `DAC_NUM_CH; ch++) begin
			if (test_sel)
				sel_data[ch] = pattern;
			else
				sel_data[ch] = data_in[ch];				// captured word
		end
	end

	// **************************************************
	// stage 2 register
	// **************************************************

	always_ff @(posedge w_glbclk1 or negedge rst_n) begin
		if (!rst_n)
			data_q <= '0;
		else
			data_q <= sel_data;
	end

	assign data_out = data_q;

endmodule

`default_nettype wire

//--- hdl/dac_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_cfg.svh"

module dac_reg_bank
	import dac_reg_pkg::*;
	import dac_data_pkg::*;
(
	input  wire logic w_glbclk1,
	input  wire logic rst_n,
	input  reg_req_t  reg_req,
	output reg_rsp_t  reg_rsp,
	output logic      test_sel,
	output dac_word_t pattern
);

	dac_word_t              pattern_q;					// REG_PAT0..7
	logic                   test_sel_q;					// REG_CTRL bit 0
	logic                   rsp_valid_q;
	logic [`DAC_REG_DW-1:0] rsp_data_q;
	logic [`DAC_REG_DW-1:0] rd_data;
	logic                   rd_hit;

	assign rd_hit = reg_req.rd & ~reg_req.wr;			// write wins a collision

	// **************************************************
	// write side
	// **************************************************

	always_ff @(posedge w_glbclk1 or negedge rst_n) begin
		if (!rst_n) begin
			pattern_q  <= '0;
			test_sel_q <= 1'b0;
		end else if (reg_req.wr) begin
			case (reg_req.addr)
				REG_PAT0, REG_PAT1, REG_PAT2, REG_PAT3,
				REG_PAT4, REG_PAT5, REG_PAT6, REG_PAT7: begin
					pattern_q[reg_req.addr[2:0]] <= reg_req.wdata;
				end
				REG_CTRL: test_sel_q <= reg_req.wdata[0];
				default: begin								// REG_ID and holes drop the write
				end
			endcase
		end
	end

	// **************************************************
	// read side
	// **************************************************

	always_comb begin
		case (reg_req.addr)
			REG_PAT0, REG_PAT1, REG_PAT2, REG_PAT3,
			REG_PAT4, REG_PAT5, REG_PAT6, REG_PAT7: begin
				rd_data = pattern_q[reg_req.addr[2:0]];
			end
			REG_CTRL: rd_data = {{(`DAC_REG_DW-1){1'b0}}, test_sel_q};
			REG_ID:   rd_data = `DAC_ID_VALUE;
			default:  rd_data = '0;						// unmapped
		endcase
	end

	always_ff @(posedge w_glbclk1 or negedge rst_n) begin
		if (!rst_n)
			rsp_valid_q <= 1'b0;
		else
			rsp_valid_q <= rd_hit;						// single pulse per strobe cycle
	end

	always_ff @(posedge w_glbclk1) begin
		if (rd_hit)
			rsp_data_q <= rd_data;
	end

	assign reg_rsp  = '{rvalid: rsp_valid_q, rdata: rsp_data_q};
	assign test_sel = test_sel_q;
	assign pattern  = pattern_q;

endmodule

`default_nettype wire

//--- hdl/dac_reg_pkg.sv
`default_nettype none

`include "dac_cfg.svh"

package dac_reg_pkg;

	// **************************************************
	// register map
	// **************************************************

	typedef enum logic [`DAC_REG_AW-1:0] {
		REG_PAT0 = 0,									// pattern sample 0
		REG_PAT1 = 1,
		REG_PAT2 = 2,
		REG_PAT3 = 3,
		REG_PAT4 = 4,
		REG_PAT5 = 5,
		REG_PAT6 = 6,
		REG_PAT7 = 7,									// pattern sample 7
		REG_CTRL = 8,									// bit 0 test select
		REG_ID   = 9									// read only
	} reg_addr_e;

	// **************************************************
	// strobe bus
	// **************************************************

	typedef struct packed {
		logic                   wr;
		logic                   rd;						// ignored while wr is high
		reg_addr_e              addr;
		logic [`DAC_REG_DW-1:0] wdata;
	} reg_req_t;

	typedef struct packed {
		logic                   rvalid;					// one cycle per read
		logic [`DAC_REG_DW-1:0] rdata;
	} reg_rsp_t;

endpackage

`default_nettype wire

//--- hdl/dac_top.sv
`timescale 1ns/1ps
`default_nettype none

module dac_top
	import dac_data_pkg::*;
	import dac_reg_pkg::*;
(
	input  wire logic  w_glbclk1,
	input  wire logic  rst_n,
	input  dac_bus_t   dac_data_in,
	input  link_stat_t link_stat,
	input  reg_req_t   reg_req,
	output reg_rsp_t   reg_rsp,
	output dac_bus_t   tx_data,
	output logic       dac_ready,
	output logic       dac_lmfc
);

	logic      test_sel;								// from REG_CTRL
	dac_word_t pattern;
	dac_bus_t  cap_data;								// stage 1 out
	dac_bus_t  pat_data;								// stage 2 out

	// **************************************************
	// control registers
	// **************************************************

	dac_reg_bank u_reg_bank (
		.w_glbclk1 ( w_glbclk1 ),
		.rst_n     ( rst_n     ),
		.reg_req   ( reg_req   ),
		.reg_rsp   ( reg_rsp   ),
		.test_sel  ( test_sel  ),
		.pattern   ( pattern   )
	);

	// **************************************************
	// three stage sample path
	// **************************************************

	dac_capture_stage u_capture (
		.w_glbclk1 ( w_glbclk1   ),
		.rst_n     ( rst_n       ),
		.data_in   ( dac_data_in ),
		.data_out  ( cap_data    )
	);

	dac_pattern_stage u_pattern (
		.w_glbclk1 ( w_glbclk1 ),
		.rst_n     ( rst_n     ),
		.data_in   ( cap_data  ),
		.test_sel  ( test_sel  ),
		.pattern   ( pattern   ),
		.data_out  ( pat_data  )
	);

	dac_lane_stage u_lane (
		.w_glbclk1 ( w_glbclk1 ),
		.rst_n     ( rst_n     ),
		.data_in   ( pat_data  ),
		.link_stat ( link_stat ),
		.tx_data   ( tx_data   ),						// to the link cores
		.dac_ready ( dac_ready ),
		.dac_lmfc  ( dac_lmfc  )
	);

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/dac_data_pkg.sv
hdl/dac_reg_pkg.sv
hdl/dac_reg_bank.sv
hdl/dac_capture_stage.sv
hdl/dac_pattern_stage.sv
hdl/dac_lane_stage.sv
hdl/dac_top.sv
bench/dac_tb.sv
